//--- logic/rename_pkg.sv
// Sizes, index typedefs and reset-mapping constants for the rename core

package rename_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int NUM_ARCH = 32;               // Architectural registers
  localparam int NUM_PR   = 48;               // Physical registers
  localparam int NUM_FL   = NUM_PR - NUM_ARCH; // Tags not mapped at reset
  localparam int NUM_ROB  = 16;               // Reorder buffer entries

  ////////////////////////////////////////////////////////////////////////////
  // Index types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [$clog2(NUM_ARCH)-1:0] arch_idx_t;  // Architectural register
  typedef logic [$clog2(NUM_PR)-1:0]   pr_tag_t;    // Physical register tag
  typedef logic [$clog2(NUM_ROB)-1:0]  rob_idx_t;   // Reorder buffer slot

  // Free list pointers and occupancy
  typedef logic [$clog2(NUM_FL)-1:0]   fl_idx_t;
  typedef logic [$clog2(NUM_FL):0]     fl_cnt_t;    // One extra bit to hold NUM_FL

  // Reorder buffer occupancy, 0 to NUM_ROB
  typedef logic [$clog2(NUM_ROB):0]    rob_cnt_t;

  ////////////////////////////////////////////////////////////////////////////
  // Fixed registers and reset contents
  ////////////////////////////////////////////////////////////////////////////

  // Hard zero, never renamed
  localparam arch_idx_t ZERO_REG = arch_idx_t'(0);

  // Arch register i maps to tag i at reset, so the free list
  // starts at the first tag above the architectural range
  localparam pr_tag_t FL_FIRST_TAG = pr_tag_t'(NUM_ARCH);

  // Full and empty levels
  localparam fl_cnt_t  FL_FULL  = fl_cnt_t'(NUM_FL);
  localparam rob_cnt_t ROB_FULL = rob_cnt_t'(NUM_ROB);

endpackage

//--- logic/free_list.sv
// free_list: circular FIFO of unallocated physical register tags

`timescale 1ns/10ps

module free_list (
  input  logic                clock,
  input  logic                reset,
  input  logic                pop,       // Hand out head_tag at the edge
  input  logic                push,      // Return push_tag at the edge
  input  rename_pkg::pr_tag_t push_tag,
  output rename_pkg::pr_tag_t head_tag,
  output logic                empty
);

  rename_pkg::pr_tag_t tags [rename_pkg::NUM_FL];
  rename_pkg::fl_idx_t head;
  rename_pkg::fl_idx_t tail;
  rename_pkg::fl_cnt_t count;
  logic                full;

  assign head_tag = tags[head];
  assign empty    = (count == '0);
  assign full     = (count == rename_pkg::FL_FULL);

  ////////////////////////////////////////////////////////////////////////////
  // Queue state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // Tags above the arch range, ascending from the head
      for (int i = 0; i < rename_pkg::NUM_FL; i++) begin
        tags[i] <= rename_pkg::FL_FIRST_TAG + rename_pkg::pr_tag_t'(i);
      end
      head  <= '0;
      tail  <= '0;  // Full, so tail has wrapped onto head
      count <= rename_pkg::FL_FULL;
    end else begin
      if (pop) begin
        head <= head + 1'b1;
      end
      if (push) begin
        tags[tail] <= push_tag;
        tail       <= tail + 1'b1;
      end

      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Dispatch must hold off while the list is dry
  pop_when_empty: assert property (
    @(posedge clock) disable iff (reset)
    !(pop && empty)
  ) else $error("free_list popped while empty");

  // A full list means no renamed tag is in flight, so retire has nothing to return
  push_when_full: assert property (
    @(posedge clock) disable iff (reset)
    !(push && full)
  ) else $error("free_list pushed while full");

endmodule

//--- logic/map_table.sv
// map_table: speculative arch-to-physical map plus per-tag ready bits

`timescale 1ns/10ps

module map_table (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  rename_valid,   // Write new mapping at the edge
  input  rename_pkg::arch_idx_t rename_reg,
  input  rename_pkg::pr_tag_t   rename_tag,
  input  rename_pkg::arch_idx_t src1_reg,
  input  rename_pkg::arch_idx_t src2_reg,
  input  rename_pkg::arch_idx_t dest_reg,
  output rename_pkg::pr_tag_t   src1_tag,
  output logic                  src1_ready,
  output rename_pkg::pr_tag_t   src2_tag,
  output logic                  src2_ready,
  output rename_pkg::pr_tag_t   dest_old_tag,
  input  logic                  wb_valid,       // Completion sets a ready bit
  input  rename_pkg::pr_tag_t   wb_tag
);

  rename_pkg::pr_tag_t         map [rename_pkg::NUM_ARCH];
  logic [rename_pkg::NUM_PR-1:0] ready;

  ////////////////////////////////////////////////////////////////////////////
  // Lookups, all combinational from the registered state
  ////////////////////////////////////////////////////////////////////////////

  // Register 0 reads as tag 0, always ready
  assign src1_tag   = (src1_reg == rename_pkg::ZERO_REG) ? '0 : map[src1_reg];
  assign src1_ready = (src1_reg == rename_pkg::ZERO_REG) ? 1'b1 : ready[src1_tag];
  assign src2_tag   = (src2_reg == rename_pkg::ZERO_REG) ? '0 : map[src2_reg];
  assign src2_ready = (src2_reg == rename_pkg::ZERO_REG) ? 1'b1 : ready[src2_tag];

  assign dest_old_tag = (dest_reg == rename_pkg::ZERO_REG) ? '0 : map[dest_reg];

  ////////////////////////////////////////////////////////////////////////////
  // Updates
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < rename_pkg::NUM_ARCH; i++) begin
        map[i] <= rename_pkg::pr_tag_t'(i);  // Identity mapping
      end
      ready <= '1;
    end else begin
      if (wb_valid) begin
        ready[wb_tag] <= 1'b1;
      end
      // New producer, value not there yet
      if (rename_valid) begin
        map[rename_reg]   <= rename_tag;
        ready[rename_tag] <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Dispatch gating keeps the hard zero out of the map
  rename_zero: assert property (
    @(posedge clock) disable iff (reset)
    rename_valid |-> (rename_reg != rename_pkg::ZERO_REG)
  ) else $error("map_table rename targets the zero register");

  // A tag comes back from retire only after its producer completed,
  // so anything popped from the free list must already read ready
  rename_stale_tag: assert property (
    @(posedge clock) disable iff (reset)
    rename_valid |-> ready[rename_tag]
  ) else $error("map_table renamed onto a tag that is still pending");

endmodule

//--- logic/reorder_buffer.sv
// reorder_buffer: in-order record of dispatched instructions, completion and retire

`timescale 1ns/10ps

module reorder_buffer (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  alloc,           // Dispatch accepted this cycle
  input  rename_pkg::arch_idx_t alloc_reg,
  input  logic                  alloc_has_dest,
  input  rename_pkg::pr_tag_t   alloc_tag,
  input  rename_pkg::pr_tag_t   alloc_old_tag,
  output rename_pkg::rob_idx_t  alloc_idx,
  output logic                  full,
  input  logic                  complete_valid,
  input  rename_pkg::rob_idx_t  complete_rob,
  output logic                  wb_valid,        // To map table ready bits
  output rename_pkg::pr_tag_t   wb_tag,
  output logic                  retire_valid,
  output rename_pkg::arch_idx_t retire_reg,
  output rename_pkg::pr_tag_t   retire_tag,
  output rename_pkg::pr_tag_t   retire_old_tag,
  output logic                  free_valid       // Old tag goes back to free list
);

  // Control bits per entry
  logic [rename_pkg::NUM_ROB-1:0] ent_valid;
  logic [rename_pkg::NUM_ROB-1:0] ent_done;

  // Payload per entry
  logic [rename_pkg::NUM_ROB-1:0] ent_has_dest;
  rename_pkg::arch_idx_t          ent_reg     [rename_pkg::NUM_ROB];
  rename_pkg::pr_tag_t            ent_tag     [rename_pkg::NUM_ROB];
  rename_pkg::pr_tag_t            ent_old_tag [rename_pkg::NUM_ROB];

  rename_pkg::rob_idx_t head;   // Oldest entry
  rename_pkg::rob_idx_t tail;   // Next free slot
  rename_pkg::rob_cnt_t count;

  assign alloc_idx = tail;
  assign full      = (count == rename_pkg::ROB_FULL);

  // Completed tag forwarded the same cycle, map table picks it up at the edge
  assign wb_valid = complete_valid && ent_valid[complete_rob] && ent_has_dest[complete_rob];
  assign wb_tag   = ent_tag[complete_rob];

  ////////////////////////////////////////////////////////////////////////////
  // Head retirement
  ////////////////////////////////////////////////////////////////////////////

  assign retire_valid   = ent_valid[head] && ent_done[head];
  assign retire_reg     = ent_reg[head];
  assign retire_tag     = ent_tag[head];
  assign retire_old_tag = ent_old_tag[head];
  assign free_valid     = retire_valid && ent_has_dest[head];

  always_ff @(posedge clock) begin
    if (reset) begin
      ent_valid <= '0;
      ent_done  <= '0;
      head      <= '0;
      tail      <= '0;
      count     <= '0;
    end else begin
      if (complete_valid) begin
        ent_done[complete_rob] <= 1'b1;
      end
      if (retire_valid) begin
        ent_valid[head] <= 1'b0;
        head            <= head + 1'b1;
      end
      // Placed last so a fresh entry always starts not done
      if (alloc) begin
        ent_valid[tail] <= 1'b1;
        ent_done[tail]  <= 1'b0;
        tail            <= tail + 1'b1;
      end

      case ({alloc, retire_valid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Payload written on allocate only
  always_ff @(posedge clock) begin
    if (alloc) begin
      ent_has_dest[tail] <= alloc_has_dest;
      ent_reg[tail]      <= alloc_reg;
      ent_tag[tail]      <= alloc_tag;
      ent_old_tag[tail]  <= alloc_old_tag;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Execution unit may only complete an in-flight entry, and only once
  complete_in_flight: assert property (
    @(posedge clock) disable iff (reset)
    complete_valid |-> (ent_valid[complete_rob] && !ent_done[complete_rob])
  ) else $error("reorder_buffer completion for entry %0d not in flight", complete_rob);

endmodule

//--- logic/rename_core.sv
// rename_core: free list, map table and reorder buffer with dispatch gating

`timescale 1ns/10ps

module rename_core (
  input  logic                  clock,
  input  logic                  reset,

  // Dispatch from the front end
  input  logic                  dispatch_valid,
  input  rename_pkg::arch_idx_t dest_reg,
  input  rename_pkg::arch_idx_t src1_reg,
  input  rename_pkg::arch_idx_t src2_reg,
  output logic                  dispatch_ready,
  output rename_pkg::pr_tag_t   dest_tag,
  output rename_pkg::pr_tag_t   old_tag,
  output rename_pkg::pr_tag_t   src1_tag,
  output logic                  src1_ready,
  output rename_pkg::pr_tag_t   src2_tag,
  output logic                  src2_ready,
  output rename_pkg::rob_idx_t  rob_tag,

  // Completion from the execution unit
  input  logic                  complete_valid,
  input  rename_pkg::rob_idx_t  complete_rob,

  // Retire
  output logic                  retire_valid,
  output rename_pkg::arch_idx_t retire_reg,
  output rename_pkg::pr_tag_t   retire_tag,
  output rename_pkg::pr_tag_t   retire_old_tag
);

  logic                accept;       // Dispatch handshake
  logic                has_dest;     // Destination other than the hard zero
  logic                do_rename;    // Pop free list and write the map
  logic                fl_empty;
  logic                rob_full;
  logic                wb_valid;
  logic                free_valid;
  rename_pkg::pr_tag_t fl_head_tag;
  rename_pkg::pr_tag_t map_old_tag;
  rename_pkg::pr_tag_t wb_tag;

  ////////////////////////////////////////////////////////////////////////////
  // Dispatch gating
  ////////////////////////////////////////////////////////////////////////////

  // Needs a free tag even for a zero destination
  assign dispatch_ready = !rob_full && !fl_empty;
  assign accept         = dispatch_valid && dispatch_ready;
  assign has_dest       = (dest_reg != rename_pkg::ZERO_REG);
  assign do_rename      = accept && has_dest;

  assign dest_tag = has_dest ? fl_head_tag : '0;
  assign old_tag  = has_dest ? map_old_tag : '0;

  free_list fl_0 (
    .clock    (clock),
    .reset    (reset),
    .pop      (do_rename),
    .push     (free_valid),      // Displaced tag from the retiring entry
    .push_tag (retire_old_tag),
    .head_tag (fl_head_tag),
    .empty    (fl_empty)
  );

  map_table map_0 (
    .clock        (clock),
    .reset        (reset),
    .rename_valid (do_rename),
    .rename_reg   (dest_reg),
    .rename_tag   (fl_head_tag),
    .src1_reg     (src1_reg),
    .src2_reg     (src2_reg),
    .dest_reg     (dest_reg),
    .src1_tag     (src1_tag),
    .src1_ready   (src1_ready),
    .src2_tag     (src2_tag),
    .src2_ready   (src2_ready),
    .dest_old_tag (map_old_tag),
    .wb_valid     (wb_valid),
    .wb_tag       (wb_tag)
  );

  reorder_buffer rob_0 (
    .clock          (clock),
    .reset          (reset),
    .alloc          (accept),        // Every accepted instruction takes a slot
    .alloc_reg      (dest_reg),
    .alloc_has_dest (has_dest),
    .alloc_tag      (dest_tag),
    .alloc_old_tag  (old_tag),
    .alloc_idx      (rob_tag),
    .full           (rob_full),
    .complete_valid (complete_valid),
    .complete_rob   (complete_rob),
    .wb_valid       (wb_valid),
    .wb_tag         (wb_tag),
    .retire_valid   (retire_valid),
    .retire_reg     (retire_reg),
    .retire_tag     (retire_tag),
    .retire_old_tag (retire_old_tag),
    .free_valid     (free_valid)
  );

endmodule

//--- tests/rename_core_tb.sv
// Testbench for rename_core, cases file loader, per-cycle drive and checks, watchdog

`timescale 1ns/10ps

module rename_core_tb;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int MAX_CASES    = 128;

  // Column order in the cases file
  localparam int COL_DV   = 0;
  localparam int COL_DEST = 1;
  localparam int COL_SRC1 = 2;
  localparam int COL_SRC2 = 3;
  localparam int COL_CV   = 4;
  localparam int COL_CROB = 5;
  localparam int COL_RDY  = 6;
  localparam int COL_DTAG = 7;
  localparam int COL_OTAG = 8;
  localparam int COL_S1T  = 9;
  localparam int COL_S1R  = 10;
  localparam int COL_S2T  = 11;
  localparam int COL_S2R  = 12;
  localparam int COL_ROB  = 13;
  localparam int COL_RV   = 14;
  localparam int COL_RREG = 15;
  localparam int COL_RTAG = 16;
  localparam int COL_ROLD = 17;
  localparam int NUM_COLS = 18;

  logic                  clock;
  logic                  reset;
  logic                  dispatch_valid;
  rename_pkg::arch_idx_t dest_reg;
  rename_pkg::arch_idx_t src1_reg;
  rename_pkg::arch_idx_t src2_reg;
  logic                  dispatch_ready;
  rename_pkg::pr_tag_t   dest_tag;
  rename_pkg::pr_tag_t   old_tag;
  rename_pkg::pr_tag_t   src1_tag;
  logic                  src1_ready;
  rename_pkg::pr_tag_t   src2_tag;
  logic                  src2_ready;
  rename_pkg::rob_idx_t  rob_tag;
  logic                  complete_valid;
  rename_pkg::rob_idx_t  complete_rob;
  logic                  retire_valid;
  rename_pkg::arch_idx_t retire_reg;
  rename_pkg::pr_tag_t   retire_tag;
  rename_pkg::pr_tag_t   retire_old_tag;

  // Case table, value plus a flag for checked fields
  logic [7:0] case_val [MAX_CASES][NUM_COLS];
  bit         case_chk [MAX_CASES][NUM_COLS];
  int         n_cases = 0;
  bit         open_ok = 0;
  bit         cases_loaded = 0;
  int         cur_case = 0;

  int checks     = 0;
  int tag_errors = 0;
  int reg_errors = 0;
  int rob_errors = 0;
  int bit_errors = 0;

  rename_core UUT (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dest_reg       (dest_reg),
    .src1_reg       (src1_reg),
    .src2_reg       (src2_reg),
    .dispatch_ready (dispatch_ready),
    .dest_tag       (dest_tag),
    .old_tag        (old_tag),
    .src1_tag       (src1_tag),
    .src1_ready     (src1_ready),
    .src2_tag       (src2_tag),
    .src2_ready     (src2_ready),
    .rob_tag        (rob_tag),
    .complete_valid (complete_valid),
    .complete_rob   (complete_rob),
    .retire_valid   (retire_valid),
    .retire_reg     (retire_reg),
    .retire_tag     (retire_tag),
    .retire_old_tag (retire_old_tag)
  );

  initial clock = 1'b0;
  always #(CLK_PERIOD / 2) clock = ~clock;

  ////////////////////////////////////////////////////////////////////////////
  // Cases file
  ////////////////////////////////////////////////////////////////////////////

  task automatic store_field(input int idx, input int col, input logic [8*16-1:0] tok);
    logic [7:0] v;
    int         code;
    if (tok == "-") begin
      case_val[idx][col] = '0;  // Unchecked
      case_chk[idx][col] = 1'b0;
    end else begin
      code = $sscanf(tok, "%h", v);
      case_val[idx][col] = v;
      case_chk[idx][col] = 1'b1;
    end
  endtask

  task automatic load_cases();
    int              fd;
    int              code;
    bit              done;
    logic [8*16-1:0] tok;
    logic [8*256-1:0] line_buf;
    done = 1'b0;
    fd   = $fopen("tests/rename_cases.txt", "r");
    if (fd == 0) begin
      open_ok = 1'b0;
    end else begin
      open_ok = 1'b1;
      while (!done) begin
        code = $fscanf(fd, "%s", tok);
        if (code != 1 || n_cases == MAX_CASES) begin
          done = 1'b1;
        end else if (tok == "#") begin
          code = $fgets(line_buf, fd);  // Comment line
        end else begin
          store_field(n_cases, 0, tok);
          for (int c = 1; c < NUM_COLS; c++) begin
            code = $fscanf(fd, "%s", tok);
            store_field(n_cases, c, tok);
          end
          n_cases++;
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_tag(input string name, input rename_pkg::pr_tag_t actual,
                           input rename_pkg::pr_tag_t expected);
    checks++;
    if (actual !== expected) begin
      tag_errors++;
      $display("ERROR at %0t, case %0d: %s = %h, expected %h",
               $time, cur_case + 1, name, actual, expected);
    end
  endtask

  task automatic check_reg(input string name, input rename_pkg::arch_idx_t actual,
                           input rename_pkg::arch_idx_t expected);
    checks++;
    if (actual !== expected) begin
      reg_errors++;
      $display("ERROR at %0t, case %0d: %s = %h, expected %h",
               $time, cur_case + 1, name, actual, expected);
    end
  endtask

  task automatic check_rob(input string name, input rename_pkg::rob_idx_t actual,
                           input rename_pkg::rob_idx_t expected);
    checks++;
    if (actual !== expected) begin
      rob_errors++;
      $display("ERROR at %0t, case %0d: %s = %h, expected %h",
               $time, cur_case + 1, name, actual, expected);
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    checks++;
    if (actual !== expected) begin
      bit_errors++;
      $display("ERROR at %0t, case %0d: %s = %b, expected %b",
               $time, cur_case + 1, name, actual, expected);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Per-cycle drive and check
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_case(input int i);
    dispatch_valid <= case_val[i][COL_DV][0];
    dest_reg       <= rename_pkg::arch_idx_t'(case_val[i][COL_DEST]);
    src1_reg       <= rename_pkg::arch_idx_t'(case_val[i][COL_SRC1]);
    src2_reg       <= rename_pkg::arch_idx_t'(case_val[i][COL_SRC2]);
    complete_valid <= case_val[i][COL_CV][0];
    complete_rob   <= rename_pkg::rob_idx_t'(case_val[i][COL_CROB]);
  endtask

  task automatic check_case(input int i);
    if (case_chk[i][COL_RDY])
      check_bit("dispatch_ready", dispatch_ready, case_val[i][COL_RDY][0]);
    if (case_chk[i][COL_DTAG])
      check_tag("dest_tag", dest_tag, rename_pkg::pr_tag_t'(case_val[i][COL_DTAG]));
    if (case_chk[i][COL_OTAG])
      check_tag("old_tag", old_tag, rename_pkg::pr_tag_t'(case_val[i][COL_OTAG]));
    if (case_chk[i][COL_S1T])
      check_tag("src1_tag", src1_tag, rename_pkg::pr_tag_t'(case_val[i][COL_S1T]));
    if (case_chk[i][COL_S1R])
      check_bit("src1_ready", src1_ready, case_val[i][COL_S1R][0]);
    if (case_chk[i][COL_S2T])
      check_tag("src2_tag", src2_tag, rename_pkg::pr_tag_t'(case_val[i][COL_S2T]));
    if (case_chk[i][COL_S2R])
      check_bit("src2_ready", src2_ready, case_val[i][COL_S2R][0]);
    if (case_chk[i][COL_ROB])
      check_rob("rob_tag", rob_tag, rename_pkg::rob_idx_t'(case_val[i][COL_ROB]));
    if (case_chk[i][COL_RV])
      check_bit("retire_valid", retire_valid, case_val[i][COL_RV][0]);
    if (case_chk[i][COL_RREG])
      check_reg("retire_reg", retire_reg, rename_pkg::arch_idx_t'(case_val[i][COL_RREG]));
    if (case_chk[i][COL_RTAG])
      check_tag("retire_tag", retire_tag, rename_pkg::pr_tag_t'(case_val[i][COL_RTAG]));
    if (case_chk[i][COL_ROLD])
      check_tag("retire_old_tag", retire_old_tag,
                rename_pkg::pr_tag_t'(case_val[i][COL_ROLD]));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dest_reg       = '0;
    src1_reg       = '0;
    src2_reg       = '0;
    complete_valid = 1'b0;
    complete_rob   = '0;

    load_cases();
    if (!open_ok || n_cases == 0) begin
      $display("Could not read any cases from tests/rename_cases.txt");
      $display("Test failed");
      $finish;
    end else begin
      cases_loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge clock);
      reset <= 1'b0;

      for (int i = 0; i < n_cases; i++) begin
        @(posedge clock);
        drive_case(i);
        @(negedge clock);  // Outputs settled, next edge not yet here
        cur_case = i;
        check_case(i);
      end

      @(posedge clock);
      dispatch_valid <= 1'b0;
      complete_valid <= 1'b0;

      $display("Checks: %0d, errors: tag %0d, reg %0d, rob %0d, bit %0d",
               checks, tag_errors, reg_errors, rob_errors, bit_errors);
      if (tag_errors + reg_errors + rob_errors + bit_errors == 0) begin
        $display("Test completed successfully");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

  // Limit scales with the number of case lines
  initial begin
    wait (cases_loaded);
    #((n_cases + RESET_CYCLES + 20) * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run hung",
             n_cases + RESET_CYCLES + 20);
    $display("Test failed");
    $finish;
  end

endmodule

//--- rename_core.f
logic/rename_pkg.sv
logic/free_list.sv
logic/map_table.sv
logic/reorder_buffer.sv
logic/rename_core.sv
tests/rename_core_tb.sv

//--- tests/rename_cases.txt
# dv dest src1 src2 cv crob | rdy dest_tag old_tag s1_tag s1_rdy s2_tag s2_rdy rob rv r_reg r_tag r_old
# All fields hex, one cycle per line, a dash leaves an expected field unchecked
# Reset state lookups
0 00 05 1f 0 0  1 00 00 05 1 1f 1 0 0 - - -
# First renames, tags 20 upward, zero destination takes no tag
1 01 01 02 0 0  1 20 01 01 1 02 1 0 0 - - -
1 02 01 00 0 0  1 21 02 20 0 00 1 1 0 - - -
1 00 02 03 0 0  1 00 00 21 0 03 1 2 0 - - -
1 01 01 04 0 0  1 22 20 20 0 04 1 3 0 - - -
# Out of order completions, same-cycle lookup still not ready
0 00 02 01 1 1  1 00 00 21 0 22 0 4 0 - - -
0 00 02 01 1 3  1 00 00 21 1 22 0 4 0 - - -
0 00 01 05 1 0  1 00 00 22 1 05 1 4 0 - - -
# In-order retire, one per cycle
0 00 00 00 0 0  1 00 00 00 1 00 1 4 1 01 20 01
0 00 02 00 1 2  1 00 00 21 1 00 1 4 1 02 21 02
0 00 00 00 0 0  1 00 00 00 1 00 1 4 1 00 00 00
0 00 01 02 0 0  1 00 00 22 1 21 1 4 1 01 22 20
0 00 03 13 0 0  1 00 00 03 1 13 1 4 0 - - -
# Sixteen dispatches drain the free list, then retired tags come back
1 03 02 00 0 0  1 23 03 21 1 00 1 4 0 - - -
1 04 03 00 0 0  1 24 04 23 0 00 1 5 0 - - -
1 05 04 00 0 0  1 25 05 24 0 00 1 6 0 - - -
1 06 05 00 0 0  1 26 06 25 0 00 1 7 0 - - -
1 07 06 00 0 0  1 27 07 26 0 00 1 8 0 - - -
1 08 07 00 0 0  1 28 08 27 0 00 1 9 0 - - -
1 09 08 00 0 0  1 29 09 28 0 00 1 a 0 - - -
1 0a 09 00 0 0  1 2a 0a 29 0 00 1 b 0 - - -
1 0b 0a 00 0 0  1 2b 0b 2a 0 00 1 c 0 - - -
1 0c 0b 00 0 0  1 2c 0c 2b 0 00 1 d 0 - - -
1 0d 0c 00 0 0  1 2d 0d 2c 0 00 1 e 0 - - -
1 0e 0d 00 0 0  1 2e 0e 2d 0 00 1 f 0 - - -
1 0f 0e 00 0 0  1 2f 0f 2e 0 00 1 0 0 - - -
1 10 0f 00 0 0  1 01 10 2f 0 00 1 1 0 - - -
1 11 10 00 0 0  1 02 11 01 0 00 1 2 0 - - -
1 12 11 00 0 0  1 20 12 02 0 00 1 3 0 - - -
# Full, dispatch ignored until the cycle after a retire
1 13 12 03 0 0  0 - 13 20 0 23 0 4 0 - - -
1 13 12 03 1 4  0 - 13 20 0 23 0 4 0 - - -
1 13 12 03 0 0  0 - 13 20 0 23 1 4 1 03 23 03
1 13 12 03 0 0  1 03 13 20 0 23 1 4 0 - - -
0 00 13 00 0 0  0 00 00 03 0 00 1 5 0 - - -
# Drain two out of order, then reuse a returned tag
0 00 05 00 1 6  0 00 00 25 0 00 1 5 0 - - -
0 00 05 00 1 5  0 00 00 25 1 00 1 5 0 - - -
0 00 05 04 0 0  0 00 00 25 1 24 1 5 1 04 24 04
0 00 00 00 0 0  1 00 00 00 1 00 1 5 1 05 25 05
1 01 01 13 0 0  1 04 22 22 1 03 0 5 0 - - -
0 00 01 00 0 0  1 00 00 04 0 00 1 6 0 - - -
